/* rv_exu_cfg.svh */
`ifndef RV_EXU_CFG_SVH
`define RV_EXU_CFG_SVH

// Data path width, W ops use the low half
`define EXU_XLEN       64

// Major opcodes
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP_32      7'b0111011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_BRANCH     7'b1100011

// 64-bit ALU ops, {funct7[5], funct3}
`define ALU_ADD        4'b0000
`define ALU_SUB        4'b1000
`define ALU_SLL        4'b0001
`define ALU_SLT        4'b0010
`define ALU_SLTU       4'b0011
`define ALU_XOR        4'b0100
`define ALU_SRL        4'b0101
`define ALU_SRA        4'b1101
`define ALU_OR         4'b0110
`define ALU_AND        4'b0111
`define ALU_LUI        4'b1111

// W ops, {1, funct7[5], funct3}
`define ALU_ADDW       5'b10000
`define ALU_SLLW       5'b10001
`define ALU_SRLW       5'b10101
`define ALU_SRAW       5'b11101
`define ALU_SUBW       5'b11000

// Branch compares, equal to funct3
`define BR_BEQ         3'b000
`define BR_BNE         3'b001
`define BR_BLT         3'b100
`define BR_BGE         3'b101
`define BR_BLTU        3'b110
`define BR_BGEU        3'b111

`endif

/* rv_exu_pkg.sv */
`include "rv_exu_cfg.svh"

package rv_exu_pkg;

  // One instruction handed over by the requester
  typedef struct packed {
    logic [31:0]           instr;
    logic [`EXU_XLEN-1:0]  pc;
    logic [`EXU_XLEN-1:0]  rs1_data;
    logic [`EXU_XLEN-1:0]  rs2_data;
  } exu_req_t;

  // Decoded ALU controls
  typedef struct packed {
    logic                  rs1_en;
    logic                  pc_en;
    logic                  rs2_en;
    logic                  imm_en;
    logic                  lgc_en;
    logic                  wlgc_en;
    logic                  br_en;
    logic [3:0]            lgc_op;
    logic [4:0]            wlgc_op;
    logic [2:0]            br_op;
    logic [`EXU_XLEN-1:0]  imm_data;
  } alu_ctrl_t;

  // Registered response returned with ack
  typedef struct packed {
    logic [`EXU_XLEN-1:0]  result;
    logic                  br_taken;
    logic                  zero;
    logic                  illegal;
  } exu_rsp_t;

endpackage

/* exu_decoder.sv */
`include "rv_exu_cfg.svh"

module exu_decoder import rv_exu_pkg::*; (
  input  logic [31:0] instr,
  output alu_ctrl_t   ctrl,
  output logic        illegal
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic                 f7_bit;
  logic                 imm_f7_bit;
  logic [`EXU_XLEN-1:0] imm_i;
  logic [`EXU_XLEN-1:0] imm_u;
  logic [`EXU_XLEN-1:0] imm_b;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign f7_bit = instr[30];

  // Only SRAI/SRAIW carry funct7[5], elsewhere it is immediate data
  assign imm_f7_bit = (funct3 == 3'b101) ? instr[30] : 1'b0;

  assign imm_i = {{(`EXU_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = {{(`EXU_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_b = {{(`EXU_XLEN-13){instr[31]}}, instr[31], instr[7],
                  instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    ctrl    = '0;
    illegal = 1'b0;
    case (opcode)
      `OPC_OP: begin
        ctrl.rs1_en = 1'b1;
        ctrl.rs2_en = 1'b1;
        ctrl.lgc_en = 1'b1;
        ctrl.lgc_op = {f7_bit, funct3};
      end
      `OPC_OP_IMM: begin
        ctrl.rs1_en   = 1'b1;
        ctrl.imm_en   = 1'b1;
        ctrl.lgc_en   = 1'b1;
        ctrl.lgc_op   = {imm_f7_bit, funct3};
        ctrl.imm_data = imm_i;
      end
      `OPC_OP_32: begin
        ctrl.rs1_en  = 1'b1;
        ctrl.rs2_en  = 1'b1;
        ctrl.wlgc_en = 1'b1;
        ctrl.wlgc_op = {1'b1, f7_bit, funct3};
      end
      `OPC_OP_IMM_32: begin
        ctrl.rs1_en   = 1'b1;
        ctrl.imm_en   = 1'b1;
        ctrl.wlgc_en  = 1'b1;
        ctrl.wlgc_op  = {1'b1, imm_f7_bit, funct3};
        ctrl.imm_data = imm_i;
      end
      `OPC_LUI: begin
        ctrl.imm_en   = 1'b1;
        ctrl.lgc_en   = 1'b1;
        ctrl.lgc_op   = `ALU_LUI;
        ctrl.imm_data = imm_u;
      end
      `OPC_AUIPC: begin
        ctrl.pc_en    = 1'b1;
        ctrl.imm_en   = 1'b1;
        ctrl.lgc_en   = 1'b1;
        ctrl.lgc_op   = `ALU_ADD;
        ctrl.imm_data = imm_u;
      end
      `OPC_BRANCH: begin
        // Target arithmetic is done elsewhere, only the compare runs here
        ctrl.rs1_en   = 1'b1;
        ctrl.rs2_en   = 1'b1;
        ctrl.br_en    = 1'b1;
        ctrl.br_op    = funct3;
        ctrl.imm_data = imm_b;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

/* alu.sv */
`include "rv_exu_cfg.svh"

module alu import rv_exu_pkg::*; (
  input  alu_ctrl_t            ctrl,
  input  logic [`EXU_XLEN-1:0] pc_data,
  input  logic [`EXU_XLEN-1:0] rs1_data,
  input  logic [`EXU_XLEN-1:0] rs2_data,
  output logic [`EXU_XLEN-1:0] result,
  output logic                 br_asrt,
  output logic                 zero
);

  localparam int XL  = `EXU_XLEN;
  localparam int WL  = XL / 2;
  localparam int SHW = $clog2(XL);

  logic [XL-1:0]    op1;
  logic [XL-1:0]    op2;
  logic [WL-1:0]    wop1;
  logic [WL-1:0]    wop2;
  logic [SHW-1:0]   shamt;
  logic [SHW-2:0]   wshamt;
  logic             eq;
  logic             lt;
  logic             ltu;
  logic [XL-1:0]    lgc_result;
  logic [WL-1:0]    wlgc_result;
  logic             br_result;

  // Operand select by enable masks
  assign op1 = ({XL{ctrl.rs1_en}} & rs1_data) |
               ({XL{ctrl.pc_en}}  & pc_data);
  assign op2 = ({XL{ctrl.rs2_en}} & rs2_data) |
               ({XL{ctrl.imm_en}} & ctrl.imm_data);

  assign wop1   = op1[WL-1:0];
  assign wop2   = op2[WL-1:0];
  assign shamt  = op2[SHW-1:0];
  assign wshamt = op2[SHW-2:0];

  // Shared by SLT/SLTU and the branch compare
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  always_comb begin
    case (ctrl.lgc_op)
      `ALU_ADD:  lgc_result = op1 + op2;
      `ALU_SUB:  lgc_result = op1 - op2;
      `ALU_XOR:  lgc_result = op1 ^ op2;
      `ALU_OR:   lgc_result = op1 | op2;
      `ALU_AND:  lgc_result = op1 & op2;
      `ALU_SLL:  lgc_result = op1 << shamt;
      `ALU_SRL:  lgc_result = op1 >> shamt;
      `ALU_SRA:  lgc_result = $signed(op1) >>> shamt;
      `ALU_SLT:  lgc_result = {{(XL-1){1'b0}}, lt};
      `ALU_SLTU: lgc_result = {{(XL-1){1'b0}}, ltu};
      `ALU_LUI:  lgc_result = op2;
      default:   lgc_result = '0;
    endcase
  end

  // W ops on the low halves
  always_comb begin
    case (ctrl.wlgc_op)
      `ALU_ADDW: wlgc_result = wop1 + wop2;
      `ALU_SUBW: wlgc_result = wop1 - wop2;
      `ALU_SLLW: wlgc_result = wop1 << wshamt;
      `ALU_SRLW: wlgc_result = wop1 >> wshamt;
      `ALU_SRAW: wlgc_result = $signed(wop1) >>> wshamt;
      default:   wlgc_result = '0;
    endcase
  end

  assign result = ({XL{ctrl.lgc_en}}  & lgc_result) |
                  ({XL{ctrl.wlgc_en}} & {{WL{wlgc_result[WL-1]}}, wlgc_result});

  assign zero = (result == '0);

  always_comb begin
    case (ctrl.br_op)
      `BR_BEQ:  br_result = eq;
      `BR_BNE:  br_result = !eq;
      `BR_BLT:  br_result = lt;
      `BR_BGE:  br_result = !lt;
      `BR_BLTU: br_result = ltu;
      `BR_BGEU: br_result = !ltu;
      default:  br_result = 1'b0;
    endcase
  end

  assign br_asrt = br_result & ctrl.br_en;

endmodule

/* exu_handshake_fsm.sv */
`include "rv_exu_cfg.svh"

module exu_handshake_fsm import rv_exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  exu_req_t             req_data,
  output exu_req_t             cur_req,
  input  logic                 illegal,
  input  logic [`EXU_XLEN-1:0] result,
  input  logic                 br_asrt,
  input  logic                 zero,
  output logic                 ack,
  output exu_rsp_t             rsp_data,
  output logic                 retire,
  output logic                 retire_br
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    RESP,
    DONE
  } state_t;

  state_t state;
  logic   capture;

  assign capture = (state == IDLE) && req;

  // Counters sample this on the edge that raises ack
  assign retire    = (state == EXEC);
  assign retire_br = retire & br_asrt;

  always_ff @(posedge clk) begin
    if (capture) begin
      cur_req <= req_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      ack      <= 1'b0;
      rsp_data <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= EXEC;
          end
        end
        EXEC: begin
          rsp_data.result   <= result;
          rsp_data.br_taken <= br_asrt;
          rsp_data.zero     <= zero;
          rsp_data.illegal  <= illegal;
          ack               <= 1'b1;
          state             <= RESP;
        end
        RESP: begin
          // Hold ack until the requester lets go of req
          if (!req) begin
            ack   <= 1'b0;
            state <= DONE;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* exu_perf_counter.sv */
module exu_perf_counter (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        retire,
  input  logic        retire_br,
  output logic [31:0] retired_cnt,
  output logic [31:0] br_taken_cnt
);

  // Both counters wrap silently
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retired_cnt <= '0;
    end else if (retire) begin
      retired_cnt <= retired_cnt + 32'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      br_taken_cnt <= '0;
    end else if (retire_br) begin
      br_taken_cnt <= br_taken_cnt + 32'd1;
    end
  end

endmodule

/* exu_top.sv */
`include "rv_exu_cfg.svh"

module exu_top import rv_exu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req,
  input  exu_req_t    req_data,
  output logic        ack,
  output exu_rsp_t    rsp_data,
  output logic [31:0] retired_cnt,
  output logic [31:0] br_taken_cnt
);

  exu_req_t             cur_req;
  alu_ctrl_t            ctrl;
  logic                 illegal;
  logic [`EXU_XLEN-1:0] result;
  logic                 br_asrt;
  logic                 zero;
  logic                 retire;
  logic                 retire_br;

  exu_handshake_fsm fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_data  (req_data),
    .cur_req   (cur_req),
    .illegal   (illegal),
    .result    (result),
    .br_asrt   (br_asrt),
    .zero      (zero),
    .ack       (ack),
    .rsp_data  (rsp_data),
    .retire    (retire),
    .retire_br (retire_br)
  );

  exu_decoder dec_i (
    .instr   (cur_req.instr),
    .ctrl    (ctrl),
    .illegal (illegal)
  );

  alu alu_i (
    .ctrl     (ctrl),
    .pc_data  (cur_req.pc),
    .rs1_data (cur_req.rs1_data),
    .rs2_data (cur_req.rs2_data),
    .result   (result),
    .br_asrt  (br_asrt),
    .zero     (zero)
  );

  exu_perf_counter perf_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire       (retire),
    .retire_br    (retire_br),
    .retired_cnt  (retired_cnt),
    .br_taken_cnt (br_taken_cnt)
  );

endmodule

/* exu_chk.sv */
module exu_chk import rv_exu_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     req,
  input exu_req_t req_data,
  input logic     ack
);

  int fail_cnt = 0;

  ack_in_reset: assert property (@(posedge clk) !rst_n |-> !ack)
    else begin
      fail_cnt++;
      $error("ack high while rst_n is low");
    end

  // Response only to a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else begin
      fail_cnt++;
      $error("ack rose without req");
    end

  ack_held: assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
    else begin
      fail_cnt++;
      $error("ack dropped while req still high");
    end

  req_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                    req && !ack |=> $stable(req_data))
    else begin
      fail_cnt++;
      $error("req_data changed before ack");
    end

endmodule

bind exu_top exu_chk chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .req      (req),
  .req_data (req_data),
  .ack      (ack)
);

/* exu_tb.sv */
`include "rv_exu_cfg.svh"

module exu_tb import rv_exu_pkg::*; ();

  localparam logic [63:0] MSB   = 64'h8000_0000_0000_0000;
  localparam logic [63:0] ONES  = '1;
  localparam logic [63:0] W_NEG = 64'hFFFF_FFFF_8000_0000;

  typedef struct packed {
    exu_req_t             req;
    logic [`EXU_XLEN-1:0] exp_result;
    logic                 exp_br;
    logic                 exp_ill;
    logic [1:0]           hold;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  exu_req_t    req_data;
  logic        ack;
  exu_rsp_t    rsp_data;
  logic [31:0] retired_cnt;
  logic [31:0] br_taken_cnt;

  row_t        rows[$];
  logic [31:0] seed;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;

  // Branch funct3 order and taken masks where bit n belongs to br_f3[n]
  logic [2:0]  br_f3 [6]    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [63:0] br_a [3]     = '{64'd5, ONES, 64'd1};
  logic [63:0] br_b [3]     = '{64'd5, 64'd1, ONES};
  logic [5:0]  br_taken [3] = '{6'b101001, 6'b100110, 6'b011010};

  exu_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .req_data     (req_data),
    .ack          (ack),
    .rsp_data     (rsp_data),
    .retired_cnt  (retired_cnt),
    .br_taken_cnt (br_taken_cnt)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("ERROR: handshake timed out, run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    seed = xorshift(seed);
    hi   = seed;
    seed = xorshift(seed);
    return {hi, seed};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] opc);
    return {imm, 5'd3, opc};
  endfunction

  // Expected value of a register-register op with the shift amount in the low 6 bits
  function automatic logic [63:0] ref_op(input logic f7b, input logic [2:0] f3,
                                         input logic [63:0] a, input logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f3)
      3'd0:    return f7b ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3:    return (a < b) ? 64'd1 : 64'd0;
      3'd4:    return a ^ b;
      3'd5:    return (f7b && a[63]) ? ~(~a >> sh) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic add_row(input logic [31:0] instr, input logic [63:0] pc,
                         input logic [63:0] rs1, input logic [63:0] rs2,
                         input logic [63:0] exp, input logic br, input logic ill);
    row_t r;
    r.req.instr    = instr;
    r.req.pc       = pc;
    r.req.rs1_data = rs1;
    r.req.rs2_data = rs2;
    r.exp_result   = exp;
    r.exp_br       = br;
    r.exp_ill      = ill;
    r.hold         = (rows.size() % 7 == 3) ? 2'd3 : 2'd0;
    rows.push_back(r);
  endtask

  task automatic alu_row(input logic [31:0] instr, input logic [63:0] rs1,
                         input logic [63:0] rs2, input logic [63:0] exp);
    add_row(instr, '0, rs1, rs2, exp, 1'b0, 1'b0);
  endtask

  task automatic apply_row(input row_t r);
    @(negedge clk);
    req_data = r.req;
    req      = 1'b1;
    while (!ack) @(negedge clk);
    check("rsp_data.illegal", 64'(rsp_data.illegal), 64'(r.exp_ill));
    check("rsp_data.br_taken", 64'(rsp_data.br_taken), 64'(r.exp_br));
    if (r.req.instr[6:0] != `OPC_BRANCH) begin
      check("rsp_data.result", rsp_data.result, r.exp_result);
      check("rsp_data.zero", 64'(rsp_data.zero), 64'(r.exp_result == '0));
    end
    // Requester stalls with req high
    repeat (r.hold) begin
      @(negedge clk);
      check("ack", 64'(ack), 64'd1);
    end
    req = 1'b0;
    while (ack) @(negedge clk);
    repeat (r.hold) @(negedge clk);
  endtask

  initial begin
    logic [2:0]  f3;
    logic        f7b;
    logic [63:0] a;
    logic [63:0] b;
    int          taken;
    int          err_before;

    clk      = 1'b0;
    rst_n    = 1'b0;
    req      = 1'b0;
    req_data = '0;
    seed     = 32'h2991_29ae;
    taken    = 0;

    alu_row(enc_r(7'h00, 3'd0, `OPC_OP), 64'd5, 64'd7, 64'd12);
    alu_row(enc_r(7'h20, 3'd0, `OPC_OP), 64'd5, 64'd7, 64'hFFFF_FFFF_FFFF_FFFE);
    alu_row(enc_r(7'h00, 3'd1, `OPC_OP), 64'd1, 64'h7F, MSB);
    alu_row(enc_r(7'h00, 3'd5, `OPC_OP), MSB, 64'd4, 64'h0800_0000_0000_0000);
    alu_row(enc_r(7'h20, 3'd5, `OPC_OP), MSB, 64'd4, 64'hF800_0000_0000_0000);
    alu_row(enc_r(7'h00, 3'd2, `OPC_OP), ONES, 64'd1, 64'd1);
    alu_row(enc_r(7'h00, 3'd3, `OPC_OP), ONES, 64'd1, 64'd0);
    alu_row(enc_r(7'h00, 3'd4, `OPC_OP), 64'hF0F0, 64'hFF00, 64'h0FF0);
    alu_row(enc_r(7'h00, 3'd6, `OPC_OP), 64'hF0F0, 64'hFF00, 64'hFFF0);
    alu_row(enc_r(7'h00, 3'd7, `OPC_OP), 64'hF0F0, 64'hFF00, 64'hF000);
    alu_row(enc_i(12'hFFD, 3'd0, `OPC_OP_IMM), 64'd10, 64'hDEAD, 64'd7);
    alu_row(enc_i(12'h408, 3'd5, `OPC_OP_IMM), MSB, 64'hDEAD, 64'hFF80_0000_0000_0000);
    alu_row(enc_i(12'h004, 3'd1, `OPC_OP_IMM), 64'd3, 64'hDEAD, 64'h30);
    alu_row(enc_i(12'hFFF, 3'd4, `OPC_OP_IMM), 64'h0F, 64'hDEAD, 64'hFFFF_FFFF_FFFF_FFF0);
    alu_row(enc_i(12'hFFF, 3'd2, `OPC_OP_IMM), 64'hFFFF_FFFF_FFFF_FFFE, '0, 64'd1);
    alu_row(enc_r(7'h00, 3'd0, `OPC_OP_32), 64'h7FFF_FFFF, 64'd1, W_NEG);
    alu_row(enc_r(7'h20, 3'd0, `OPC_OP_32), 64'hAAAA_AAAA_0000_0001, 64'd2, ONES);
    alu_row(enc_r(7'h00, 3'd1, `OPC_OP_32), 64'd1, 64'h3F, W_NEG);
    alu_row(enc_r(7'h00, 3'd5, `OPC_OP_32), W_NEG, 64'd4, 64'h0800_0000);
    alu_row(enc_r(7'h20, 3'd5, `OPC_OP_32), W_NEG, 64'd4, 64'hFFFF_FFFF_F800_0000);
    alu_row(enc_i(12'hFFB, 3'd0, `OPC_OP_IMM_32), 64'h1_0000_0005, '0, 64'd0);
    alu_row(enc_i(12'h401, 3'd5, `OPC_OP_IMM_32), 64'h8000_0000, '0, 64'hFFFF_FFFF_C000_0000);
    alu_row(enc_u(20'hFEDCB, `OPC_LUI), 64'h55, 64'h66, 64'hFFFF_FFFF_FEDC_B000);
    add_row(enc_u(20'h00001, `OPC_AUIPC), 64'h1000, 64'h55, '0, 64'h2000, 1'b0, 1'b0);
    add_row(32'h0020_8003, '0, 64'd9, 64'd9, '0, 1'b0, 1'b1);
    add_row(32'h0000_006F, '0, 64'd9, 64'd9, '0, 1'b0, 1'b1);

    for (int p = 0; p < 3; p++) begin
      for (int c = 0; c < 6; c++) begin
        add_row(enc_r(7'h00, br_f3[c], `OPC_BRANCH), '0, br_a[p], br_b[p], '0,
                br_taken[p][c], 1'b0);
      end
    end

    // Random operands with SUB and SRA in the last two rows
    for (int i = 0; i < 10; i++) begin
      f3  = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
      f7b = (i >= 8);
      a   = rand64();
      b   = rand64();
      alu_row(enc_r(f7b ? 7'h20 : 7'h00, f3, `OPC_OP), a, b, ref_op(f7b, f3, a, b));
    end

    cycle_limit = rows.size() * 12 + 50;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    err_before = errors;
    check("ack", 64'(ack), '0);
    check("retired_cnt", 64'(retired_cnt), '0);
    check("br_taken_cnt", 64'(br_taken_cnt), '0);
    report("reset", err_before);

    foreach (rows[i]) begin
      err_before = errors;
      apply_row(rows[i]);
      report($sformatf("row %0d instr %h", i, rows[i].req.instr), err_before);
      if (rows[i].exp_br) begin
        taken++;
      end
    end

    err_before = errors;
    check("retired_cnt", 64'(retired_cnt), 64'(rows.size()));
    check("br_taken_cnt", 64'(br_taken_cnt), 64'(taken));
    report("counters", err_before);

    $display("%0d tests, %0d failed, %0d assertion failures", tests_run, tests_failed,
             dut_i.chk_i.fail_cnt);
    if (tests_failed == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
rv_exu_pkg.sv
exu_decoder.sv
alu.sv
exu_handshake_fsm.sv
exu_perf_counter.sv
exu_top.sv
exu_chk.sv
exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module exu_tb -f project.f -o exu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/exu_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  exit 0
fi
echo "Simulation did not report success, see $LOG"
exit 1
